//--- source/mul_core_defines.svh
/*
 * Shared widths, field positions and opcodes of the core
 * Immediate and rs2 fields overlap, each opcode uses only one of them
 * Opcode values must stay unique, decode has no priority between them
 */
`ifndef MUL_CORE_DEFINES_SVH
`define MUL_CORE_DEFINES_SVH

`define MC_DATA_W        32
`define MC_REG_CNT       16
`define MC_REG_AW        4
`define MC_IMM_W         16

// Instruction field positions
`define MC_OPC_HI        31
`define MC_OPC_LO        25
`define MC_RD_HI         24
`define MC_RD_LO         21
`define MC_RS1_HI        20
`define MC_RS1_LO        17
`define MC_RS2_HI        16
`define MC_RS2_LO        13
`define MC_IMM_HI        15
`define MC_IMM_LO        0

// Opcodes, 7 bits
`define MC_OP_MOV        7'b0000000
`define MC_OP_ADD        7'b0110001
`define MC_OP_ADDS       7'b0111001
`define MC_OP_SUB        7'b0110010
`define MC_OP_SUBI       7'b0010010
`define MC_OP_NOT        7'b0110110
`define MC_OP_NOP        7'b1100100
`define MC_OP_MULI       7'b1000001
`define MC_OP_MULR       7'b1000010
`define MC_OP_MULSI      7'b1000011
`define MC_OP_MULSR      7'b1000100

`define MC_DRAIN_CYCLES  2  // Cycles for older instructions to commit

`endif

//--- source/mul_core_pkg.sv
/*
 * Enumerated types shared by decode, execute and the multiply sequencer
 * Flags travel as a plain 4-bit NZCV vector, no type here
 */
package mul_core_pkg;

    // Decoded ALU operation
    typedef enum logic [2:0] {
        ALU_MOV,   // Rd = zero extended immediate
        ALU_ADD,
        ALU_ADDS,  // Same math as ADD, marks the signed multiply form
        ALU_SUB,
        ALU_SUBI,
        ALU_NOT,
        ALU_NOP
    } alu_op_t;

    // Multiply forms
    typedef enum logic [1:0] {
        MUL_I,   // Unsigned immediate multiplier
        MUL_R,   // Unsigned register multiplier
        MUL_SI,  // Signed immediate multiplier
        MUL_SR   // Signed register multiplier
    } mul_kind_t;

    // Microcode sequencer states
    typedef enum logic [3:0] {
        S_IDLE,
        S_DRAIN,
        S_CLEAR,
        S_MOV,
        S_ADD,
        S_FIX_SUB,
        S_FIX_NOT,
        S_HALT,
        S_RELEASE
    } useq_state_t;

endpackage

//--- source/instr_decode.sv
/*
 * Decode stage, one instruction per cycle
 * Injected instruction wins over the external port
 * Multiplies go to the sequencer only, never on to execute
 * Unknown opcodes decode as NOP
 */
`include "mul_core_defines.svh"

module instr_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  logic [`MC_DATA_W-1:0]     instr,
    input  logic                      inject,
    input  logic [`MC_DATA_W-1:0]     inject_instr,
    output logic                      dec_valid,
    output mul_core_pkg::alu_op_t     dec_op,
    output logic [`MC_REG_AW-1:0]     dec_rd,
    output logic [`MC_REG_AW-1:0]     dec_rs1,
    output logic [`MC_REG_AW-1:0]     dec_rs2,
    output logic [`MC_IMM_W-1:0]      dec_imm,
    output logic                      start_mul,
    output mul_core_pkg::mul_kind_t   mul_kind
);
    import mul_core_pkg::*;

    logic [`MC_DATA_W-1:0] sel_instr;
    logic                  sel_valid;
    logic [6:0]            opc;
    alu_op_t               op_d;
    mul_kind_t             kind_d;
    logic                  is_mul;

    assign sel_instr = inject ? inject_instr : instr;  // Sequencer has priority
    assign sel_valid = inject | instr_valid;
    assign opc       = sel_instr[`MC_OPC_HI:`MC_OPC_LO];

    always_comb begin
        op_d   = ALU_NOP;
        kind_d = MUL_I;
        is_mul = 1'b0;
        case (opc)
            `MC_OP_MOV:   op_d = ALU_MOV;
            `MC_OP_ADD:   op_d = ALU_ADD;
            `MC_OP_ADDS:  op_d = ALU_ADDS;
            `MC_OP_SUB:   op_d = ALU_SUB;
            `MC_OP_SUBI:  op_d = ALU_SUBI;
            `MC_OP_NOT:   op_d = ALU_NOT;
            `MC_OP_MULI:  begin is_mul = 1'b1; kind_d = MUL_I;  end
            `MC_OP_MULR:  begin is_mul = 1'b1; kind_d = MUL_R;  end
            `MC_OP_MULSI: begin is_mul = 1'b1; kind_d = MUL_SI; end
            `MC_OP_MULSR: begin is_mul = 1'b1; kind_d = MUL_SR; end
            default:      op_d = ALU_NOP;  // NOP and unknown codes
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
            start_mul <= 1'b0;
        end else begin
            dec_valid <= sel_valid & ~is_mul;
            start_mul <= sel_valid & is_mul;  // Single cycle, one per accepted MUL
        end
    end

    // Field payload, qualified by dec_valid or start_mul
    always_ff @(posedge clk) begin
        dec_op   <= op_d;
        mul_kind <= kind_d;
        dec_rd   <= sel_instr[`MC_RD_HI:`MC_RD_LO];
        dec_rs1  <= sel_instr[`MC_RS1_HI:`MC_RS1_LO];
        dec_rs2  <= sel_instr[`MC_RS2_HI:`MC_RS2_LO];
        dec_imm  <= sel_instr[`MC_IMM_HI:`MC_IMM_LO];
    end

    // External source must stay quiet while the sequencer owns decode
    a_no_collide: assert property (@(posedge clk) disable iff (rst)
        !(instr_valid && inject));

endmodule

//--- source/mul_ucode_seq.sv
/*
 * Microcode sequencer for MULI, MULR, MULSI and MULSR
 * Rd equal to Rs is not supported
 * Only the low 16 bits of a register multiplier count
 * Latency grows with the multiplier magnitude, busy marks the whole run
 */
`include "mul_core_defines.svh"

module mul_ucode_seq (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start_mul,
    input  mul_core_pkg::mul_kind_t   mul_kind,
    input  logic [`MC_REG_AW-1:0]     dest_reg,
    input  logic [`MC_REG_AW-1:0]     source_reg,
    input  logic [`MC_REG_AW-1:0]     mul_rs2,
    input  logic [`MC_IMM_W-1:0]      immediate,
    output logic [`MC_REG_AW-1:0]     seq_rd_addr,
    input  logic [`MC_DATA_W-1:0]     seq_rd_data,
    input  logic [3:0]                flags_in,
    output logic                      inject,
    output logic [`MC_DATA_W-1:0]     inject_instr,
    output logic                      busy,
    output logic                      mul_release,
    output logic [3:0]                restore_flags
);
    import mul_core_pkg::*;

    localparam logic [3:0] DRAIN_LAST = 4'(`MC_DRAIN_CYCLES - 1);

    useq_state_t            state;
    logic [3:0]             drain_cnt;
    logic [`MC_IMM_W-1:0]   count;      // ADDs still to inject
    logic [`MC_IMM_W-1:0]   imm_q;
    logic [`MC_IMM_W-1:0]   mul_val;
    logic [`MC_IMM_W-1:0]   mul_mag;
    logic [`MC_REG_AW-1:0]  dest_q;
    logic [`MC_REG_AW-1:0]  src_q;
    logic [`MC_REG_AW-1:0]  rs2_q;
    mul_kind_t              kind_q;
    logic                   signed_form;
    logic                   mul_neg;
    logic                   neg_q;
    logic                   drain_done;
    logic [3:0]             flags_hold;
    logic [6:0]             add_opc;

    assign seq_rd_addr = rs2_q;  // Multiplier register, read while draining
    assign signed_form = (kind_q == MUL_SI) || (kind_q == MUL_SR);
    assign mul_val     = (kind_q == MUL_R || kind_q == MUL_SR) ?
                         seq_rd_data[`MC_IMM_W-1:0] : imm_q;
    assign mul_neg     = signed_form & mul_val[`MC_IMM_W-1];
    assign mul_mag     = mul_neg ? -mul_val : mul_val;  // 0x8000 stays a valid count
    assign add_opc     = signed_form ? `MC_OP_ADDS : `MC_OP_ADD;
    assign drain_done  = (state == S_DRAIN) && (drain_cnt == 4'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            drain_cnt <= 4'd0;
            count     <= '0;
        end else begin
            case (state)
                S_IDLE: if (start_mul) begin
                    state     <= S_DRAIN;
                    drain_cnt <= DRAIN_LAST;
                end
                S_DRAIN: begin
                    drain_cnt <= drain_cnt - 4'd1;
                    if (drain_cnt == 4'd0) begin
                        count <= mul_mag;
                        if (mul_mag == '0)
                            state <= S_CLEAR;  // Zero multiplier, just clear Rd
                        else
                            state <= S_MOV;
                    end
                end
                S_CLEAR: state <= S_HALT;
                S_MOV:   state <= S_ADD;
                S_ADD: begin
                    count <= count - 1'b1;
                    if (count == 1) begin
                        if (neg_q)
                            state <= S_FIX_SUB;
                        else
                            state <= S_HALT;
                    end
                end
                S_FIX_SUB: state <= S_FIX_NOT;
                S_FIX_NOT: state <= S_HALT;
                S_HALT:    state <= S_RELEASE;  // Last injected op reaches execute
                S_RELEASE: state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    // Operand capture, no reset needed
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start_mul) begin
            dest_q <= dest_reg;
            src_q  <= source_reg;
            rs2_q  <= mul_rs2;
            kind_q <= mul_kind;
            imm_q  <= immediate;
        end
        if (drain_done) begin
            neg_q      <= mul_neg;
            flags_hold <= flags_in;  // Older ops all committed by now
        end
    end

    always_comb begin
        inject       = 1'b1;
        inject_instr = {`MC_OP_NOP, 25'b0};
        case (state)
            S_CLEAR:   inject_instr = {`MC_OP_SUB, dest_q, dest_q, dest_q, 13'b0};
            S_MOV:     inject_instr = {`MC_OP_MOV, dest_q, 21'b0};
            S_ADD:     inject_instr = {add_opc, dest_q, dest_q, src_q, 13'b0};
            S_FIX_SUB: inject_instr = {`MC_OP_SUBI, dest_q, dest_q, 1'b0, 16'd1};
            S_FIX_NOT: inject_instr = {`MC_OP_NOT, dest_q, dest_q, 17'b0};  // ~(x-1) = -x
            default:   inject       = 1'b0;
        endcase
    end

    assign busy          = start_mul | (state != S_IDLE);
    assign mul_release   = (state == S_RELEASE);
    assign restore_flags = flags_hold;

    // An ADD run always has one ADD left, a zero count goes through clear
    a_add_count: assert property (@(posedge clk) disable iff (rst)
        (state == S_ADD) |-> (count != '0));
    // Decode must not start a second multiply while one runs
    a_start_in_idle: assert property (@(posedge clk) disable iff (rst)
        start_mul |-> state == S_IDLE);

endmodule

//--- source/alu_execute.sv
/*
 * Execute stage with forwarding from its own result register
 * Flags follow ARM style NZCV, C is the no-borrow bit on subtract
 * MOV and NOP leave the flags alone, NOT clears C and V
 */
`include "mul_core_defines.svh"

module alu_execute (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dec_valid,
    input  mul_core_pkg::alu_op_t   dec_op,
    input  logic [`MC_REG_AW-1:0]   dec_rd,
    input  logic [`MC_REG_AW-1:0]   dec_rs1,
    input  logic [`MC_REG_AW-1:0]   dec_rs2,
    input  logic [`MC_IMM_W-1:0]    dec_imm,
    output logic [`MC_REG_AW-1:0]   rs1_addr,
    output logic [`MC_REG_AW-1:0]   rs2_addr,
    input  logic [`MC_DATA_W-1:0]   rs1_data,
    input  logic [`MC_DATA_W-1:0]   rs2_data,
    output logic                    ex_valid,
    output logic [`MC_REG_AW-1:0]   ex_addr,
    output logic [`MC_DATA_W-1:0]   ex_data,
    output logic [3:0]              ex_flags,
    output logic                    ex_flag_we
);
    import mul_core_pkg::*;

    localparam int W = `MC_DATA_W;

    logic [W-1:0] a, b, imm_x, sub_b, res;
    logic [W:0]   sum;
    logic         c, v, flag_we;

    assign rs1_addr = dec_rs1;
    assign rs2_addr = dec_rs2;
    // Previous op is still in flight, take it from the result register
    assign a        = (ex_valid && ex_addr == dec_rs1) ? ex_data : rs1_data;
    assign b        = (ex_valid && ex_addr == dec_rs2) ? ex_data : rs2_data;
    assign imm_x    = {{(W-`MC_IMM_W){1'b0}}, dec_imm};
    assign sub_b    = (dec_op == ALU_SUBI) ? imm_x : b;

    always_comb begin
        sum     = '0;
        res     = '0;
        c       = 1'b0;
        v       = 1'b0;
        flag_we = 1'b0;
        case (dec_op)
            ALU_MOV: res = imm_x;
            ALU_ADD, ALU_ADDS: begin
                sum     = {1'b0, a} + {1'b0, b};
                res     = sum[W-1:0];
                c       = sum[W];
                v       = (a[W-1] == b[W-1]) && (res[W-1] != a[W-1]);
                flag_we = 1'b1;
            end
            ALU_SUB, ALU_SUBI: begin
                sum     = {1'b0, a} + {1'b0, ~sub_b} + 1'b1;  // a - b
                res     = sum[W-1:0];
                c       = sum[W];
                v       = (a[W-1] != sub_b[W-1]) && (res[W-1] != a[W-1]);
                flag_we = 1'b1;
            end
            ALU_NOT: begin
                res     = ~a;
                flag_we = 1'b1;
            end
            default: res = '0;  // NOP writes nothing
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid   <= 1'b0;
            ex_flag_we <= 1'b0;
        end else begin
            ex_valid   <= dec_valid && (dec_op != ALU_NOP);
            ex_flag_we <= dec_valid && flag_we;
        end
    end

    always_ff @(posedge clk) begin
        ex_addr  <= dec_rd;
        ex_data  <= res;
        ex_flags <= {res[W-1], ~|res, c, v};
    end

endmodule

//--- source/reg_result.sv
/*
 * Register file, NZCV and writeback commit
 * Reads are combinational, forwarding lives in execute
 * A flags restore from the sequencer beats the ALU flag write
 */
`include "mul_core_defines.svh"

module reg_result (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ex_valid,
    input  logic [`MC_REG_AW-1:0]   ex_addr,
    input  logic [`MC_DATA_W-1:0]   ex_data,
    input  logic [3:0]              ex_flags,
    input  logic                    ex_flag_we,
    input  logic [`MC_REG_AW-1:0]   rs1_addr,
    input  logic [`MC_REG_AW-1:0]   rs2_addr,
    input  logic [`MC_REG_AW-1:0]   seq_rd_addr,
    input  logic [`MC_REG_AW-1:0]   rd_addr,
    output logic [`MC_DATA_W-1:0]   rs1_data,
    output logic [`MC_DATA_W-1:0]   rs2_data,
    output logic [`MC_DATA_W-1:0]   seq_rd_data,
    output logic [`MC_DATA_W-1:0]   rd_data,
    input  logic                    mul_release,
    input  logic [3:0]              restore_flags,
    output logic [3:0]              flags,
    output logic                    wb_valid,
    output logic [`MC_REG_AW-1:0]   wb_addr,
    output logic [`MC_DATA_W-1:0]   wb_data
);
    logic [`MC_DATA_W-1:0] regs [`MC_REG_CNT];

    assign rs1_data    = regs[rs1_addr];
    assign rs2_data    = regs[rs2_addr];
    assign seq_rd_data = regs[seq_rd_addr];
    assign rd_data     = regs[rd_addr];  // Debug port

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MC_REG_CNT; i++)
                regs[i] <= '0;
            flags <= 4'b0;
        end else begin
            if (ex_valid)
                regs[ex_addr] <= ex_data;
            if (mul_release)
                flags <= restore_flags;  // Undo the flags of the injected ops
            else if (ex_valid && ex_flag_we)
                flags <= ex_flags;
        end
    end

    // Commit stream, visible the cycle before the write lands
    assign wb_valid = ex_valid;
    assign wb_addr  = ex_addr;
    assign wb_data  = ex_data;

endmodule

//--- source/mul_core_top.sv
/*
 * Core slice top, decode, sequencer, execute and register file
 * instr_valid must stay low while busy is high
 * wb outputs include the injected microcode instructions
 */
`include "mul_core_defines.svh"

module mul_core_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  logic [`MC_DATA_W-1:0]   instr,
    output logic                    busy,
    input  logic [`MC_REG_AW-1:0]   rd_addr,
    output logic [`MC_DATA_W-1:0]   rd_data,
    output logic [3:0]              flags,
    output logic                    wb_valid,
    output logic [`MC_REG_AW-1:0]   wb_addr,
    output logic [`MC_DATA_W-1:0]   wb_data
);
    import mul_core_pkg::*;

    // Decode to execute and sequencer
    logic                   dec_valid, start_mul;
    alu_op_t                dec_op;
    mul_kind_t              mul_kind;
    logic [`MC_REG_AW-1:0]  dec_rd, dec_rs1, dec_rs2;
    logic [`MC_IMM_W-1:0]   dec_imm;
    // Sequencer paths
    logic                   inject, mul_release;
    logic [`MC_DATA_W-1:0]  inject_instr;
    logic [`MC_REG_AW-1:0]  seq_rd_addr;
    logic [`MC_DATA_W-1:0]  seq_rd_data;
    logic [3:0]             restore_flags;
    // Execute and register file
    logic [`MC_REG_AW-1:0]  rs1_addr, rs2_addr, ex_addr;
    logic [`MC_DATA_W-1:0]  rs1_data, rs2_data, ex_data;
    logic                   ex_valid, ex_flag_we;
    logic [3:0]             ex_flags;

    instr_decode u_decode (
        .clk, .rst, .instr_valid, .instr, .inject, .inject_instr,
        .dec_valid, .dec_op, .dec_rd, .dec_rs1, .dec_rs2, .dec_imm,
        .start_mul, .mul_kind
    );

    mul_ucode_seq u_seq (
        .clk, .rst, .start_mul, .mul_kind,
        .dest_reg(dec_rd), .source_reg(dec_rs1), .mul_rs2(dec_rs2), .immediate(dec_imm),
        .seq_rd_addr, .seq_rd_data, .flags_in(flags),
        .inject, .inject_instr, .busy, .mul_release, .restore_flags
    );

    alu_execute u_exec (
        .clk, .rst, .dec_valid, .dec_op, .dec_rd, .dec_rs1, .dec_rs2, .dec_imm,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .ex_valid, .ex_addr, .ex_data, .ex_flags, .ex_flag_we
    );

    reg_result u_regs (
        .clk, .rst, .ex_valid, .ex_addr, .ex_data, .ex_flags, .ex_flag_we,
        .rs1_addr, .rs2_addr, .seq_rd_addr, .rd_addr,
        .rs1_data, .rs2_data, .seq_rd_data, .rd_data,
        .mul_release, .restore_flags, .flags, .wb_valid, .wb_addr, .wb_data
    );

endmodule

//--- verification/mul_core_checker.sv
/*
 * Checker of the core slice, compares DUT ports with model values from the testbench
 * Commit stream is compared in order against commits queued by the model
 * Register reads need rd_addr already settled by the caller
 * seq_state is the sequencer state, used only in timeout text
 */
module mul_core_checker (
    input logic                      clk,
    input logic                      rst,
    input logic                      busy,
    input logic                      wb_valid,
    input logic [3:0]                wb_addr,
    input logic [31:0]               wb_data,
    input logic [3:0]                flags,
    input logic [31:0]               rd_data,
    input mul_core_pkg::useq_state_t seq_state
);
    timeunit 1ns;
    timeprecision 100ps;
    import mul_core_pkg::*;

    int errors       = 0;
    int test_base    = 0;  // Error count when the current test began
    int test_num     = 0;
    int tests_failed = 0;
    int commits      = 0;
    logic [35:0] exp_commits [$];  // {addr, data} in commit order
    logic [35:0] next_commit;

    // Queued by the model before the instruction is sent
    function automatic void expect_commit(input logic [3:0] addr, input logic [31:0] data);
        exp_commits.push_back({addr, data});
    endfunction

    // Commit stream compared in order, includes injected microcode ops
    always @(posedge clk) begin
        if (!rst && wb_valid) begin
            commits++;
            if (exp_commits.size() == 0) begin
                errors++;
                $display("Unexpected commit of r%0d at %0d ns, the model expects none",
                         wb_addr, $time);
            end else begin
                next_commit = exp_commits.pop_front();
                if ({wb_addr, wb_data} !== next_commit) begin
                    errors++;
                    $display("Mismatch at %0d ns: commit r%0d = %h, model has r%0d = %h",
                             $time, wb_addr, wb_data, next_commit[35:32], next_commit[31:0]);
                end
            end
        end
    end

    task automatic check_reg(input logic [3:0] addr, input logic [31:0] expected);
        if (rd_data !== expected) begin
            errors++;
            $display("Mismatch at %0d ns: r%0d reads %h, model has %h",
                     $time, addr, rd_data, expected);
        end
    endtask

    task automatic check_flags(input logic [3:0] expected);
        if (flags !== expected) begin
            errors++;
            $display("Mismatch at %0d ns: NZCV reads %b, model has %b",
                     $time, flags, expected);
        end
    endtask

    // Quiet outputs expected right after reset
    task automatic check_idle_outputs();
        if (busy !== 1'b0) begin
            errors++;
            $display("Mismatch at %0d ns: busy is %b after reset", $time, busy);
        end
        if (wb_valid !== 1'b0) begin
            errors++;
            $display("Mismatch at %0d ns: wb_valid is %b after reset", $time, wb_valid);
        end
    endtask

    task automatic report_timeout(input string what, input int limit);
        errors++;
        $display("Timeout: busy stayed high for %0d cycles during %s, sequencer in %s",
                 limit, what, seq_state.name());
    endtask

    task automatic end_test(input string name);
        int n;
        if (exp_commits.size() != 0) begin
            errors++;
            $display("%0d expected commits never appeared on the writeback port",
                     exp_commits.size());
            exp_commits.delete();
        end
        n = errors - test_base;
        test_num++;
        if (n != 0)
            tests_failed++;
        $display("Test %0d %s: %s, %0d mismatches", test_num, name,
                 (n == 0) ? "ok" : "FAILED", n);
        test_base = errors;
    endtask

    task automatic report_counts();
        $display("Tests run %0d, failed %0d, mismatches %0d, commits seen %0d",
                 test_num, tests_failed, errors, commits);
    endtask

endmodule

//--- verification/mul_core_tb.sv
/*
 * Testbench of the core slice, seeded random ALU and multiply stimulus
 * Reference model keeps sixteen registers and NZCV
 * Multiplies use Rd different from Rs, magnitudes up to 20
 * Inputs change 5 ns after the rising edge
 */
`include "mul_core_defines.svh"

module mul_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MAX_MAG        = 20;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [3:0]  rd_addr;
    logic        busy;
    logic [31:0] rd_data;
    logic [3:0]  flags;
    logic        wb_valid;
    logic [3:0]  wb_addr;
    logic [31:0] wb_data;

    logic [31:0] model_regs [16];
    logic [3:0]  model_flags;
    integer      seed;

    mul_core_top u_dut (
        .clk, .rst, .instr_valid, .instr, .busy, .rd_addr, .rd_data,
        .flags, .wb_valid, .wb_addr, .wb_data
    );

    mul_core_checker u_chk (
        .clk, .rst, .busy, .wb_valid, .wb_addr, .wb_data, .flags, .rd_data,
        .seq_state(u_dut.u_seq.state)  // Only for timeout text
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] encode_reg_form(input logic [6:0] opc,
            input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] rs2);
        return {opc, rd, rs1, rs2, 13'b0};
    endfunction

    function automatic logic [31:0] encode_imm_form(input logic [6:0] opc,
            input logic [3:0] rd, input logic [3:0] rs1, input logic [15:0] imm);
        return {opc, rd, rs1, 1'b0, imm};
    endfunction

    // ALU rules, C is carry out on add and no borrow on subtract
    function automatic void model_alu(input logic [6:0] opc, input logic [3:0] rd,
            input logic [3:0] rs1, input logic [3:0] rs2, input logic [15:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        longint      s;
        a = model_regs[rs1];
        b = (opc == `MC_OP_SUBI) ? {16'b0, imm} : model_regs[rs2];
        case (opc)
            `MC_OP_MOV: model_regs[rd] = {16'b0, imm};  // Flags untouched
            `MC_OP_ADD, `MC_OP_ADDS: begin
                res = a + b;
                s   = longint'($signed(a)) + longint'($signed(b));  // Exact signed sum
                model_regs[rd] = res;
                model_flags    = {res[31], res == 0, res < a, s != longint'($signed(res))};
            end
            `MC_OP_SUB, `MC_OP_SUBI: begin
                res = a - b;
                s   = longint'($signed(a)) - longint'($signed(b));
                model_regs[rd] = res;
                model_flags    = {res[31], res == 0, a >= b, s != longint'($signed(res))};
            end
            `MC_OP_NOT: begin
                res = ~a;
                model_regs[rd] = res;
                model_flags    = {res[31], res == 0, 2'b00};
            end
            default: ;  // NOP
        endcase
        if (opc != `MC_OP_NOP)
            u_chk.expect_commit(rd, model_regs[rd]);
    endfunction

    // Rd = Rs times multiplier mod 2^32, flags unchanged
    // Every injected instruction shows up as one commit to Rd
    function automatic void model_mul(input logic [6:0] opc, input logic [3:0] rd,
            input logic [3:0] rs, input logic [3:0] rs2, input logic [15:0] imm);
        logic [15:0] m16;
        longint      m;
        longint      mag;
        logic [63:0] prod;
        logic [31:0] acc;
        m16 = (opc == `MC_OP_MULR || opc == `MC_OP_MULSR) ? model_regs[rs2][15:0] : imm;
        if (opc == `MC_OP_MULSI || opc == `MC_OP_MULSR)
            m = longint'($signed(m16));
        else
            m = longint'(m16);
        prod = longint'(model_regs[rs]) * m;
        mag  = (m < 0) ? -m : m;
        acc  = 32'd0;
        u_chk.expect_commit(rd, 32'd0);  // Clear or MOV Rd,0
        for (int i = 0; i < mag; i++) begin
            acc = acc + model_regs[rs];  // One ADD per unit
            u_chk.expect_commit(rd, acc);
        end
        if (m < 0) begin
            u_chk.expect_commit(rd, acc - 32'd1);
            u_chk.expect_commit(rd, prod[31:0]);  // NOT leaves the negated sum
        end
        model_regs[rd] = prod[31:0];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic send_word(input logic [31:0] word);
        instr_valid = 1'b1;
        instr       = word;
        next_cycle();  // Accepted at this edge
        instr_valid = 1'b0;
    endtask

    task automatic wait_not_busy(input string what);
        int cycles;
        cycles = 0;
        while (busy && cycles < TIMEOUT_CYCLES) begin
            next_cycle();
            cycles++;
        end
        if (busy) begin
            u_chk.report_timeout(what, TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    endtask

    task automatic issue_alu(input logic [6:0] opc, input logic [3:0] rd,
            input logic [3:0] rs1, input logic [3:0] rs2, input logic [15:0] imm);
        model_alu(opc, rd, rs1, rs2, imm);
        if (opc == `MC_OP_MOV || opc == `MC_OP_SUBI)
            send_word(encode_imm_form(opc, rd, rs1, imm));
        else
            send_word(encode_reg_form(opc, rd, rs1, rs2));
    endtask

    task automatic issue_mul(input logic [6:0] opc, input logic [3:0] rd,
            input logic [3:0] rs, input logic [3:0] rs2, input logic [15:0] imm);
        model_mul(opc, rd, rs, rs2, imm);
        if (opc == `MC_OP_MULR || opc == `MC_OP_MULSR)
            send_word(encode_reg_form(opc, rd, rs, rs2));
        else
            send_word(encode_imm_form(opc, rd, rs, imm));
        wait_not_busy("a multiply");
    endtask

    // Last op commits two edges after acceptance
    task automatic compare_all_state();
        repeat (3) next_cycle();
        for (int i = 0; i < 16; i++) begin
            rd_addr = 4'(i);
            #1;
            u_chk.check_reg(4'(i), model_regs[i]);
        end
        u_chk.check_flags(model_flags);
    endtask

    task automatic run_alu_sequence(input int n);
        logic [6:0]  opc;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  last_rd;
        int          sel;
        last_rd = 4'd0;
        for (int k = 0; k < n; k++) begin
            sel = $unsigned($random(seed)) % 7;
            rd  = 4'($random(seed));
            rs1 = (k % 3 == 1) ? last_rd : 4'($random(seed));  // Dependent back to back
            case (sel)
                0:       opc = `MC_OP_MOV;
                1:       opc = `MC_OP_ADD;
                2:       opc = `MC_OP_ADDS;
                3:       opc = `MC_OP_SUB;
                4:       opc = `MC_OP_SUBI;
                5:       opc = `MC_OP_NOT;
                default: opc = `MC_OP_NOP;
            endcase
            issue_alu(opc, rd, rs1, 4'($random(seed)), 16'($random(seed)));
            last_rd = rd;
        end
    endtask

    // Register forms load the multiplier with MOV right before the multiply
    task automatic random_mul(input logic [6:0] opc, input int lo, input int hi,
            input logic negative);
        int          mag;
        logic [15:0] mval;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [3:0]  rs2;
        mag  = lo + ($unsigned($random(seed)) % (hi - lo + 1));
        mval = negative ? 16'(-mag) : 16'(mag);
        rd   = 4'($random(seed));
        rs   = 4'($random(seed));
        if (rs == rd)
            rs = rd + 4'd1;  // Rd equal to Rs not supported
        rs2  = 4'($random(seed));
        if (opc == `MC_OP_MULR || opc == `MC_OP_MULSR) begin
            issue_alu(`MC_OP_MOV, rs2, 4'd0, 4'd0, mval);
            issue_mul(opc, rd, rs, rs2, 16'd0);
        end else begin
            issue_mul(opc, rd, rs, 4'd0, mval);
        end
        compare_all_state();
    endtask

    initial begin
        seed        = 40;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rd_addr     = '0;
        for (int i = 0; i < 16; i++)
            model_regs[i] = '0;
        model_flags = 4'b0;
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;

        u_chk.check_idle_outputs();
        compare_all_state();
        u_chk.end_test("reset state");

        run_alu_sequence(200);
        compare_all_state();
        u_chk.end_test("random ALU sequence");

        for (int n = 0; n < 8; n++)
            random_mul((n % 2 == 1) ? `MC_OP_MULR : `MC_OP_MULI, 1, MAX_MAG, 1'b0);
        u_chk.end_test("unsigned multiply");

        for (int n = 0; n < 8; n++)
            random_mul((n % 2 == 1) ? `MC_OP_MULSR : `MC_OP_MULSI, 1, MAX_MAG, 1'b1);
        u_chk.end_test("signed negative multiply");

        random_mul(`MC_OP_MULI, 0, 0, 1'b0);
        random_mul(`MC_OP_MULR, 0, 0, 1'b0);
        random_mul(`MC_OP_MULSI, 0, 0, 1'b0);
        random_mul(`MC_OP_MULSR, 0, 0, 1'b0);
        random_mul(`MC_OP_MULI, 1, 1, 1'b0);
        random_mul(`MC_OP_MULR, 1, 1, 1'b0);
        random_mul(`MC_OP_MULSI, 1, 1, 1'b0);
        random_mul(`MC_OP_MULSR, 1, 1, 1'b0);
        u_chk.end_test("zero and one multiplier");

        // ADD feeds the multiplier register, then the source register
        issue_alu(`MC_OP_MOV, 4'd3, 4'd0, 4'd0, 16'd5);
        issue_alu(`MC_OP_MOV, 4'd4, 4'd0, 4'd0, 16'd2);
        issue_alu(`MC_OP_MOV, 4'd2, 4'd0, 4'd0, 16'h1234);
        issue_alu(`MC_OP_ADD, 4'd3, 4'd3, 4'd4, 16'd0);
        issue_mul(`MC_OP_MULR, 4'd1, 4'd2, 4'd3, 16'd0);
        issue_alu(`MC_OP_ADD, 4'd2, 4'd5, 4'd6, 16'd0);
        issue_mul(`MC_OP_MULSI, 4'd7, 4'd2, 4'd0, 16'(-3));
        compare_all_state();
        u_chk.end_test("multiply after dependent ADD");

        u_chk.report_counts();
        if (u_chk.errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+source
source/mul_core_pkg.sv
source/instr_decode.sv
source/mul_ucode_seq.sv
source/alu_execute.sv
source/reg_result.sv
source/mul_core_top.sv
verification/mul_core_checker.sv
verification/mul_core_tb.sv

//--- Bender.yml
package:
  name: mul_core

export_include_dirs:
  - source

sources:
  - target: rtl
    files:
      - source/mul_core_pkg.sv
      - source/instr_decode.sv
      - source/mul_ucode_seq.sv
      - source/alu_execute.sv
      - source/reg_result.sv
      - source/mul_core_top.sv
  - target: test
    files:
      - verification/mul_core_checker.sv
      - verification/mul_core_tb.sv
